// ==== Makefile ====
# Verilator build for the MIPS core testbench

TOP = mipsCoreTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f \
		--top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== dv/mipsCoreTb.sv ====
/*
 * MIPS core testbench: directed programs run to halt, results
 * checked against the memory model
 */
`timescale 1ns/1ps

module mipsCoreTb;
    import mipsPkg::*;

    localparam logic [31:0] resetVector = 32'h0000_0100;
    localparam logic [31:0] dataBase    = 32'h0000_0800;
    localparam logic [31:0] sentinel    = 32'h5a5a_5a5a;
    localparam int memWords    = 1024;
    localparam int resetCycles = 10;
    localparam int haltWatch   = 20;
    localparam int numTests    = 5;
    // words loaded per test, code plus data
    localparam int programWords = 3 + 32 + 41 + 23 + 3;
    // one load cycle and up to 3 run cycles per word, resets, margin
    localparam int timeoutCycles =
        programWords * 4 + numTests * (resetCycles + 4) + haltWatch + 100;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] memReadData, memAddr, memWriteData;
    logic        memRead, memWrite, halt;
    logic [3:0]  byteEn;
    logic        loadEnable, clearEnable;
    logic [31:0] loadAddr, loadData;

    logic [31:0] loadAddrQ[$], loadDataQ[$], expectAddrQ[$], expectDataQ[$];
    logic [31:0] codeAddr, resultAddr;
    logic [31:0] lcgState = 32'h8f058e19;
    logic [31:0] snapshot [memWords];
    int cycleCount  = 0;
    int errorCount  = 0;
    int testErrors  = 0;
    int testsRun    = 0;
    int testsFailed = 0;

    mipsCore #(.resetVector(resetVector)) uut (
        .clk(clk), .reset(reset), .memReadData(memReadData), .memAddr(memAddr),
        .memWriteData(memWriteData), .memRead(memRead), .memWrite(memWrite),
        .byteEn(byteEn), .halt(halt)
    );

    mipsTbMemory #(.depth(memWords)) uMemory (
        .clk(clk), .addr(memAddr), .writeData(memWriteData), .read(memRead),
        .write(memWrite), .byteEn(byteEn), .readData(memReadData),
        .loadEnable(loadEnable), .clearEnable(clearEnable),
        .loadAddr(loadAddr), .loadData(loadData)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // hang guard
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: the core did not halt within %0d cycles", cycleCount);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // instruction encoding
    // ------------------------------------------------------------
    function automatic logic [31:0] rType(logic [5:0] fn, int rs, int rt, int rd);
        return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    // word index of the target, upper bits from the region
    function automatic logic [31:0] jType(logic [5:0] op, logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    function automatic logic [31:0] sw(int rt, logic [31:0] addr);
        return iType(OP_SW, 0, rt, addr[15:0]);
    endfunction

    function automatic logic [31:0] lw(int rt, logic [31:0] addr);
        return iType(OP_LW, 0, rt, addr[15:0]);
    endfunction

    function automatic logic [31:0] jr(int rs);
        return rType(FN_JR, rs, 0, 0);
    endfunction

    // numerical recipes LCG
    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // ------------------------------------------------------------
    // program building and running
    // ------------------------------------------------------------
    task automatic startTest();
        loadAddrQ.delete();
        loadDataQ.delete();
        expectAddrQ.delete();
        expectDataQ.delete();
        codeAddr   = resetVector;
        resultAddr = dataBase;
        testErrors = 0;
    endtask

    task automatic emit(logic [31:0] word);
        loadAddrQ.push_back(codeAddr);
        loadDataQ.push_back(word);
        codeAddr += 4;
    endtask

    task automatic place(logic [31:0] addr, logic [31:0] word);
        loadAddrQ.push_back(addr);
        loadDataQ.push_back(word);
    endtask

    task automatic expectWord(logic [31:0] addr, logic [31:0] value);
        expectAddrQ.push_back(addr);
        expectDataQ.push_back(value);
    endtask

    // result lands in r3, then goes to the next result slot
    task automatic storeResult(logic [31:0] instr, logic [31:0] expected);
        emit(instr);
        emit(sw(3, resultAddr));
        expectWord(resultAddr, expected);
        resultAddr += 4;
    endtask

    task automatic checkValue(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, got);
            errorCount++;
            testErrors++;
        end
    endtask

    // core sits in reset or HALT here, so the port is free
    task automatic loadProgram();
        @(posedge clk);
        #1;
        clearEnable = 1'b1;
        @(posedge clk);
        #1;
        clearEnable = 1'b0;
        for (int i = 0; i < loadAddrQ.size(); i++) begin
            loadEnable = 1'b1;
            loadAddr   = loadAddrQ[i];
            loadData   = loadDataQ[i];
            @(posedge clk);
            #1;
        end
        loadEnable = 1'b0;
    endtask

    // returns 1 ns after the edge that leaves reset
    task automatic resetCore();
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic runToHalt();
        while (halt !== 1'b1) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic runProgram();
        loadProgram();
        resetCore();
        runToHalt();
    endtask

    task automatic checkResults();
        for (int i = 0; i < expectAddrQ.size(); i++)
            checkValue($sformatf("mem[%h]", expectAddrQ[i]),
                       uMemory.peek(expectAddrQ[i]), expectDataQ[i]);
    endtask

    task automatic finishTest(string name);
        testsRun++;
        if (testErrors == 0) begin
            $display("%s: passed", name);
        end else begin
            testsFailed++;
            $display("%s: failed with %0d errors", name, testErrors);
        end
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------
    task automatic resetFetchTest();
        startTest();
        emit(iType(OP_ADDIU, 0, 1, 16'h1234));
        emit(sw(1, dataBase));
        emit(jr(0));
        expectWord(dataBase, 32'h0000_1234);
        loadProgram();
        resetCore();
        // first cycle out of reset fetches the reset vector
        checkValue("memRead", {31'd0, memRead}, 32'd1);
        checkValue("memAddr", memAddr, resetVector);
        checkValue("memWrite", {31'd0, memWrite}, 32'd0);
        // word accesses only
        checkValue("byteEn", {28'd0, byteEn}, 32'h0000_000f);
        @(posedge clk);
        #1;
        // EXEC1 of an ALU op, bus quiet
        checkValue("memRead", {31'd0, memRead}, 32'd0);
        @(posedge clk);
        #1;
        checkValue("memRead", {31'd0, memRead}, 32'd1);
        checkValue("memAddr", memAddr, resetVector + 32'd4);
        runToHalt();
        checkResults();
        finishTest("reset and fetch");
    endtask

    task automatic arithmeticTest();
        logic [31:0] a, b;
        startTest();
        a = 32'h8765_4321;
        b = 32'hffff_fffd;
        // r1 = a by lui/ori, r2 = b by addiu of -3
        emit(iType(OP_LUI, 0, 1, 16'h8765));
        emit(iType(OP_ORI, 1, 1, 16'h4321));
        emit(iType(OP_ADDIU, 0, 2, 16'hfffd));
        storeResult(rType(FN_ADDU, 1, 2, 3), a + b);
        storeResult(rType(FN_SUBU, 1, 2, 3), a - b);
        storeResult(rType(FN_AND, 1, 2, 3), a & b);
        storeResult(rType(FN_OR, 1, 2, 3), a | b);
        storeResult(rType(FN_XOR, 1, 2, 3), a ^ b);
        storeResult(rType(FN_SLT, 1, 2, 3), ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        // zero against a negative word, signed and unsigned disagree
        storeResult(rType(FN_SLTU, 0, 1, 3), (32'd0 < a) ? 32'd1 : 32'd0);
        // logic immediates zero-extended
        storeResult(iType(OP_ANDI, 1, 3, 16'hf0f0), a & 32'h0000_f0f0);
        storeResult(iType(OP_ORI, 2, 3, 16'h1234), b | 32'h0000_1234);
        storeResult(iType(OP_XORI, 1, 3, 16'hffff), a ^ 32'h0000_ffff);
        // compare and add immediates sign-extended
        storeResult(iType(OP_SLTI, 2, 3, 16'hfffc),
                    ($signed(b) < $signed(32'hffff_fffc)) ? 32'd1 : 32'd0);
        storeResult(iType(OP_SLTIU, 1, 3, 16'h7fff), (a < 32'h0000_7fff) ? 32'd1 : 32'd0);
        storeResult(iType(OP_ADDIU, 1, 3, 16'h8001), a + 32'hffff_8001);
        storeResult(iType(OP_LUI, 0, 3, 16'hbeef), 32'hbeef_0000);
        emit(jr(0));
        runProgram();
        checkResults();
        finishTest("arithmetic and logic");
    endtask

    task automatic randomTest();
        logic [31:0] x, y, slot;
        startTest();
        for (int k = 0; k < 4; k++) begin
            x = nextRandom();
            y = nextRandom();
            // operand pairs above the result area
            slot = dataBase + 32'h200 + k * 8;
            place(slot, x);
            place(slot + 4, y);
            emit(lw(1, slot));
            emit(lw(2, slot + 4));
            storeResult(rType(FN_ADDU, 1, 2, 3), x + y);
            storeResult(rType(FN_SUBU, 1, 2, 3), x - y);
            storeResult(rType(FN_SLT, 1, 2, 3), ($signed(x) < $signed(y)) ? 32'd1 : 32'd0);
        end
        emit(jr(0));
        runProgram();
        checkResults();
        finishTest("random operands");
    endtask

    task automatic controlFlowTest();
        logic [31:0] jalAddr;
        startTest();
        // r5 == r6, r5 != r7, r4 is the marker
        emit(iType(OP_ADDIU, 0, 5, 16'd7));
        emit(iType(OP_ADDIU, 0, 6, 16'd7));
        emit(iType(OP_ADDIU, 0, 7, 16'd9));
        emit(iType(OP_ADDIU, 0, 4, 16'h0011));
        // beq taken skips one store
        emit(iType(OP_BEQ, 5, 6, 16'd1));
        emit(sw(4, dataBase));
        // beq not taken
        emit(iType(OP_BEQ, 5, 7, 16'd1));
        emit(sw(4, dataBase + 32'h04));
        // bne taken
        emit(iType(OP_BNE, 5, 7, 16'd1));
        emit(sw(4, dataBase + 32'h08));
        // bne not taken
        emit(iType(OP_BNE, 5, 6, 16'd1));
        emit(sw(4, dataBase + 32'h0c));
        emit(jType(OP_J, codeAddr + 8));
        emit(sw(4, dataBase + 32'h10));
        // call, then link and marker after the return
        jalAddr = codeAddr;
        emit(jType(OP_JAL, codeAddr + 16));
        emit(sw(31, dataBase + 32'h18));
        emit(sw(4, dataBase + 32'h1c));
        emit(jr(0));
        // subroutine
        emit(sw(4, dataBase + 32'h14));
        emit(jr(31));
        // skipped stores must leave these alone
        place(dataBase, sentinel);
        place(dataBase + 32'h08, sentinel);
        place(dataBase + 32'h10, sentinel);
        expectWord(dataBase, sentinel);
        expectWord(dataBase + 32'h04, 32'h11);
        expectWord(dataBase + 32'h08, sentinel);
        expectWord(dataBase + 32'h0c, 32'h11);
        expectWord(dataBase + 32'h10, sentinel);
        expectWord(dataBase + 32'h14, 32'h11);
        expectWord(dataBase + 32'h18, jalAddr + 32'd4);
        expectWord(dataBase + 32'h1c, 32'h11);
        runProgram();
        checkResults();
        finishTest("control flow");
    endtask

    task automatic haltTest();
        startTest();
        emit(iType(OP_ADDIU, 0, 1, 16'h0055));
        emit(sw(1, dataBase));
        emit(jr(0));
        expectWord(dataBase, 32'h0000_0055);
        runProgram();
        for (int i = 0; i < memWords; i++)
            snapshot[i] = uMemory.peek(i * 4);
        // halted core keeps the port quiet, from the halt cycle on
        repeat (haltWatch) begin
            checkValue("memRead", {31'd0, memRead}, 32'd0);
            checkValue("memWrite", {31'd0, memWrite}, 32'd0);
            checkValue("halt", {31'd0, halt}, 32'd1);
            @(posedge clk);
            #1;
        end
        for (int i = 0; i < memWords; i++)
            checkValue($sformatf("mem[%h]", i * 4), uMemory.peek(i * 4), snapshot[i]);
        checkResults();
        finishTest("halt");
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        reset       = 1'b1;
        loadEnable  = 1'b0;
        clearEnable = 1'b0;
        loadAddr    = 32'd0;
        loadData    = 32'd0;
        resetFetchTest();
        arithmeticTest();
        randomTest();
        controlFlowTest();
        haltTest();
        $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== dv/mipsTbMemory.sv ====
/*
 * word memory model for the core testbench: one-cycle read latency,
 * byte-enable writes, bulk fill and word loading
 */
`timescale 1ns/1ps

module mipsTbMemory #(
    parameter int depth = 1024
) (
    input  logic        clk,
    input  logic [31:0] addr,
    input  logic [31:0] writeData,
    input  logic        read,
    input  logic        write,
    input  logic [3:0]  byteEn,
    input  logic        loadEnable,
    input  logic        clearEnable,
    input  logic [31:0] loadAddr,
    input  logic [31:0] loadData,
    output logic [31:0] readData
);

    localparam int indexBits = $clog2(depth);

    logic [31:0] mem [depth];
    logic [31:0] readReg = 32'd0;

    // fill value follows the byte address, a stray read shows its origin
    function automatic logic [31:0] fillPattern(int index);
        logic [31:0] byteAddr;
        byteAddr = index << 2;
        return {~byteAddr[15:0], byteAddr[15:0]};
    endfunction

    // word at a byte address, for the checks
    function automatic logic [31:0] peek(logic [31:0] byteAddr);
        return mem[byteAddr[indexBits+1:2]];
    endfunction

    always @(posedge clk) begin
        // clear and load only happen while the core is in reset or halted
        if (clearEnable) begin
            for (int i = 0; i < depth; i++)
                mem[i] <= fillPattern(i);
        end else if (loadEnable) begin
            mem[loadAddr[indexBits+1:2]] <= loadData;
        end else if (write) begin
            for (int b = 0; b < 4; b++)
                if (byteEn[b])
                    mem[addr[indexBits+1:2]][8*b +: 8] <= writeData[8*b +: 8];
        end
        // data shows up one cycle after the read strobe
        if (read)
            readReg <= mem[addr[indexBits+1:2]];
    end

    assign readData = readReg;

endmodule

// ==== hdl/mipsAlu.sv ====
/*
 * MIPS ALU: immediate extension, operand select, arithmetic, logic,
 * compares and load-upper, plus the rs/rt equality flag
 */
`timescale 1ns/1ps

module mipsAlu (
    input  logic [31:0] operandA,
    input  logic [31:0] registerB,
    input  logic [15:0] offset,
    input  logic        aluSrc,
    input  logic [4:0]  aluControl,
    output logic [31:0] aluResult,
    output logic        equal
);
    import mipsPkg::*;

    logic        zeroExtend;
    logic [31:0] extOffset;
    logic [31:0] operandB;

    // ------------------------------------------------------------
    // operand B
    // ------------------------------------------------------------
    // logic immediates are unsigned
    assign zeroExtend = aluControl == ALU_AND || aluControl == ALU_OR ||
                        aluControl == ALU_XOR;
    assign extOffset = zeroExtend ? {16'd0, offset} : {{16{offset[15]}}, offset};
    // high selects the register, low the immediate
    assign operandB = aluSrc ? registerB : extOffset;

    // ------------------------------------------------------------
    // operations
    // ------------------------------------------------------------
    always_comb begin
        case (aluControl)
            ALU_SUB:  aluResult = operandA - operandB;
            ALU_AND:  aluResult = operandA & operandB;
            ALU_OR:   aluResult = operandA | operandB;
            ALU_XOR:  aluResult = operandA ^ operandB;
            ALU_SLT:  aluResult = {31'd0, $signed(operandA) < $signed(operandB)};
            ALU_SLTU: aluResult = {31'd0, operandA < operandB};
            // immediate into the upper half
            ALU_LUI:  aluResult = {operandB[15:0], 16'd0};
            default:  aluResult = operandA + operandB;
        endcase
    end

    // branch compare is always rs against rt
    assign equal = operandA == registerB;

endmodule

// ==== hdl/mipsCore.sv ====
/*
 * MIPS multicycle core top level: wires the blocks together and
 * muxes the memory address and register write-back
 */
`timescale 1ns/1ps

module mipsCore #(
    parameter logic [31:0] resetVector = 32'h0000_0100
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] memReadData,
    output logic [31:0] memAddr,
    output logic [31:0] memWriteData,
    output logic        memRead,
    output logic        memWrite,
    output logic [3:0]  byteEn,
    output logic        halt
);
    import mipsPkg::*;

    stateT       state;
    instructionT instruction;
    logic        decMemRead, memSrc, regWrite, regSrc, aluSrc, cntEn, extra;
    logic [1:0]  regData, pcControl;
    logic [4:0]  aluControl, writeAddr;
    logic        equal;
    logic [31:0] aluResult, readDataA, readDataB, writeData, pc, pcPlusFour;

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    mipsDecoder uDecoder (
        .instruction(instruction), .state(state), .equal(equal),
        .memRead(decMemRead), .memWrite(memWrite), .byteEn(byteEn),
        .memSrc(memSrc), .regWrite(regWrite), .regSrc(regSrc),
        .regData(regData), .aluSrc(aluSrc), .aluControl(aluControl),
        .pcControl(pcControl), .cntEn(cntEn), .extra(extra)
    );

    mipsSequencer uSequencer (
        .clk(clk), .reset(reset), .extra(extra), .halt(halt),
        .memReadData(memReadData), .state(state), .instruction(instruction)
    );

    // ------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------
    mipsRegisterFile uRegisterFile (
        .clk(clk),
        .readAddrA(instruction.rFields.rs), .readAddrB(instruction.rFields.rt),
        .writeEnable(regWrite), .writeAddr(writeAddr), .writeData(writeData),
        .readDataA(readDataA), .readDataB(readDataB)
    );

    mipsAlu uAlu (
        .operandA(readDataA), .registerB(readDataB),
        .offset(instruction.iFields.offset), .aluSrc(aluSrc),
        .aluControl(aluControl), .aluResult(aluResult), .equal(equal)
    );

    mipsProgramCounter #(.resetVector(resetVector)) uProgramCounter (
        .clk(clk), .reset(reset), .cntEn(cntEn), .pcControl(pcControl),
        .instruction(instruction), .registerA(readDataA),
        .pc(pc), .pcPlusFour(pcPlusFour), .halt(halt)
    );

    // jal links into r31, R-type into rd, the rest into rt
    assign writeAddr = (regData == WB_LINK) ? 5'd31 :
                       regSrc ? instruction.rFields.rd : instruction.rFields.rt;

    always_comb begin
        case (regData)
            WB_MEM:  writeData = memReadData;
            WB_LINK: writeData = pcPlusFour;
            default: writeData = aluResult;
        endcase
    end

    // memory port
    assign memAddr      = memSrc ? pc : aluResult;
    assign memWriteData = readDataB;
    // no fetch from address 0
    assign memRead      = decMemRead && !halt;

endmodule

// ==== hdl/mipsDecoder.sv ====
/*
 * MIPS instruction decoder: turns the opcode, function field and
 * FSM state into the datapath control strobes
 */
`timescale 1ns/1ps

module mipsDecoder (
    input  mipsPkg::instructionT instruction,
    input  mipsPkg::stateT       state,
    input  logic                 equal,
    output logic                 memRead,
    output logic                 memWrite,
    output logic [3:0]           byteEn,
    output logic                 memSrc,
    output logic                 regWrite,
    output logic                 regSrc,
    output logic [1:0]           regData,
    output logic                 aluSrc,
    output logic [4:0]           aluControl,
    output logic [1:0]           pcControl,
    output logic                 cntEn,
    output logic                 extra
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] fncode;
    logic isSpecial;
    logic isAddu, isSubu, isAnd, isOr, isXor, isSlt, isSltu, isJr;
    logic isAddiu, isAndi, isOri, isXori, isSlti, isSltiu, isLui;
    logic isLw, isSw, isBeq, isBne, isJ, isJal;
    logic rAlu, iAlu, load, store, threeCycle, twoCycle, branchTaken;

    assign opcode = instruction.rFields.opcode;
    assign fncode = instruction.rFields.fncode;

    // ------------------------------------------------------------
    // per-instruction flags
    // ------------------------------------------------------------
    assign isSpecial = opcode == OP_SPECIAL;
    assign isAddu    = isSpecial && fncode == FN_ADDU;
    assign isSubu    = isSpecial && fncode == FN_SUBU;
    assign isAnd     = isSpecial && fncode == FN_AND;
    assign isOr      = isSpecial && fncode == FN_OR;
    assign isXor     = isSpecial && fncode == FN_XOR;
    assign isSlt     = isSpecial && fncode == FN_SLT;
    assign isSltu    = isSpecial && fncode == FN_SLTU;
    assign isJr      = isSpecial && fncode == FN_JR;

    assign isAddiu = opcode == OP_ADDIU;
    assign isAndi  = opcode == OP_ANDI;
    assign isOri   = opcode == OP_ORI;
    assign isXori  = opcode == OP_XORI;
    assign isSlti  = opcode == OP_SLTI;
    assign isSltiu = opcode == OP_SLTIU;
    assign isLui   = opcode == OP_LUI;
    assign isLw    = opcode == OP_LW;
    assign isSw    = opcode == OP_SW;
    assign isBeq   = opcode == OP_BEQ;
    assign isBne   = opcode == OP_BNE;
    assign isJ     = opcode == OP_J;
    assign isJal   = opcode == OP_JAL;

    // classification
    assign rAlu = isAddu || isSubu || isAnd || isOr || isXor || isSlt || isSltu;
    assign iAlu = isAddiu || isAndi || isOri || isXori || isSlti || isSltiu || isLui;
    assign load       = isLw;
    assign store      = isSw;
    assign threeCycle = load || store;
    assign twoCycle   = !threeCycle;

    // bne takes the branch on a mismatch
    assign branchTaken = (isBeq && equal) || (isBne && !equal);

    // ------------------------------------------------------------
    // strobes per state
    // ------------------------------------------------------------
    always_comb begin
        // idle values, also what HALT keeps
        memRead    = 1'b0;
        memWrite   = 1'b0;
        byteEn     = 4'b1111;
        memSrc     = 1'b1;
        regWrite   = 1'b0;
        regSrc     = 1'b0;
        regData    = WB_ALU;
        aluSrc     = 1'b0;
        aluControl = ALU_ADD;
        pcControl  = PC_SEQ;
        cntEn      = 1'b0;
        extra      = 1'b0;

        case (state)
            FETCH: begin
                // instruction read at pc
                memRead = 1'b1;
            end
            EXEC1: begin
                // loads and stores put the ALU sum on the bus
                memSrc   = twoCycle;
                memRead  = load;
                memWrite = store;
                regWrite = rAlu || iAlu || isJal;
                regSrc   = rAlu;
                regData  = isJal ? WB_LINK : WB_ALU;
                aluSrc   = rAlu;
                cntEn    = twoCycle;
                extra    = threeCycle;

                if (isSubu)
                    aluControl = ALU_SUB;
                else if (isAnd || isAndi)
                    aluControl = ALU_AND;
                else if (isOr || isOri)
                    aluControl = ALU_OR;
                else if (isXor || isXori)
                    aluControl = ALU_XOR;
                else if (isSlt || isSlti)
                    aluControl = ALU_SLT;
                else if (isSltu || isSltiu)
                    aluControl = ALU_SLTU;
                else if (isLui)
                    aluControl = ALU_LUI;

                if (isJ || isJal)
                    pcControl = PC_JUMP;
                else if (isJr)
                    pcControl = PC_REG;
                else if (branchTaken)
                    pcControl = PC_BRANCH;
            end
            EXEC2: begin
                // load data arrives now, pc moves on
                regWrite = load;
                regData  = WB_MEM;
                cntEn    = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // the shared port cannot read and write in one cycle
    always_comb begin
        assert (!(memRead && memWrite))
            else $error("memRead and memWrite both high");
    end

endmodule

// ==== hdl/mipsPkg.sv ====
/*
 * MIPS core shared definitions: FSM states, opcode and function
 * fields, ALU operations, write-back and next-PC selects
 */
package mipsPkg;

    // ------------------------------------------------------------
    // sequencer states
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        FETCH = 2'b00,
        EXEC1 = 2'b01,
        EXEC2 = 2'b10,
        HALT  = 2'b11
    } stateT;

    // ------------------------------------------------------------
    // instruction word, three views of the same 32 bits
    // ------------------------------------------------------------
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sa;
        logic [5:0] fncode;
    } rTypeT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        // signed for arithmetic, zero-extended for logic ops
        logic [15:0] offset;
    } iTypeT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] instrIndex;
    } jTypeT;

    typedef union packed {
        rTypeT rFields;
        iTypeT iFields;
        jTypeT jFields;
    } instructionT;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    // function codes under SPECIAL
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    // ALU operations
    localparam logic [4:0] ALU_ADD  = 5'd0;
    localparam logic [4:0] ALU_SUB  = 5'd1;
    localparam logic [4:0] ALU_AND  = 5'd2;
    localparam logic [4:0] ALU_OR   = 5'd3;
    localparam logic [4:0] ALU_XOR  = 5'd4;
    localparam logic [4:0] ALU_SLT  = 5'd5;
    localparam logic [4:0] ALU_SLTU = 5'd6;
    localparam logic [4:0] ALU_LUI  = 5'd7;

    // register write-back source
    localparam logic [1:0] WB_MEM  = 2'b00;
    localparam logic [1:0] WB_LINK = 2'b01;
    localparam logic [1:0] WB_ALU  = 2'b10;

    // next program counter source
    localparam logic [1:0] PC_JUMP   = 2'b00;
    localparam logic [1:0] PC_BRANCH = 2'b01;
    localparam logic [1:0] PC_REG    = 2'b10;
    localparam logic [1:0] PC_SEQ    = 2'b11;

endpackage

// ==== hdl/mipsProgramCounter.sv ====
/*
 * MIPS program counter: next-address select for sequential, branch,
 * register and jump targets, and halt on address zero
 */
`timescale 1ns/1ps

module mipsProgramCounter #(
    parameter logic [31:0] resetVector = 32'h0000_0100
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cntEn,
    input  logic [1:0]           pcControl,
    input  mipsPkg::instructionT instruction,
    input  logic [31:0]          registerA,
    output logic [31:0]          pc,
    output logic [31:0]          pcPlusFour,
    output logic                 halt
);
    import mipsPkg::*;

    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic [31:0] nextPc;

    assign pcPlusFour = pc + 32'd4;

    // word offset relative to the next instruction
    assign branchTarget = pcPlusFour +
        {{14{instruction.iFields.offset[15]}}, instruction.iFields.offset, 2'b00};

    // stays in the current 256 MB region
    assign jumpTarget = {pcPlusFour[31:28], instruction.jFields.instrIndex, 2'b00};

    always_comb begin
        case (pcControl)
            PC_JUMP:   nextPc = jumpTarget;
            PC_BRANCH: nextPc = branchTarget;
            PC_REG:    nextPc = registerA;
            default:   nextPc = pcPlusFour;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            pc <= resetVector;
        else if (cntEn)
            pc <= nextPc;
    end

    // a program ends by jumping to address 0
    assign halt = pc == 32'd0;

endmodule

// ==== hdl/mipsRegisterFile.sv ====
/*
 * MIPS register file: 32 x 32 bits, two async reads, one sync write,
 * register 0 reads as zero
 */
`timescale 1ns/1ps

module mipsRegisterFile (
    input  logic        clk,
    input  logic [4:0]  readAddrA,
    input  logic [4:0]  readAddrB,
    input  logic        writeEnable,
    input  logic [4:0]  writeAddr,
    input  logic [31:0] writeData,
    output logic [31:0] readDataA,
    output logic [31:0] readDataB
);

    logic [31:0] regs [32];

    // r0 cleared on every edge, the later assignment overrides a write to it
    always_ff @(posedge clk) begin
        if (writeEnable)
            regs[writeAddr] <= writeData;
        regs[0] <= 32'd0;
    end

    // plain array reads, r0 zero comes from the storage
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

    // whatever was written, r0 stays zero on both ports
    zeroRegister: assert property (
        @(posedge clk)
        writeEnable |=> (readAddrA != 5'd0 || readDataA == 32'd0) &&
                        (readAddrB != 5'd0 || readDataB == 32'd0)
    ) else $error("register 0 read nonzero");

endmodule

// ==== hdl/mipsSequencer.sv ====
/*
 * MIPS sequencer: FETCH/EXEC1/EXEC2/HALT FSM and the instruction
 * register, with a bypass of the fetched word during EXEC1
 */
`timescale 1ns/1ps

module mipsSequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 extra,
    input  logic                 halt,
    input  logic [31:0]          memReadData,
    output mipsPkg::stateT       state,
    output mipsPkg::instructionT instruction
);
    import mipsPkg::*;

    stateT       nextState;
    instructionT instrReg;

    // ------------------------------------------------------------
    // state register
    // ------------------------------------------------------------
    always_comb begin
        case (state)
            FETCH:   nextState = halt ? HALT : EXEC1;
            EXEC1:   nextState = extra ? EXEC2 : FETCH;
            EXEC2:   nextState = FETCH;
            default: nextState = HALT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= FETCH;
        else
            state <= nextState;
    end

    // fetched word is on memReadData only during EXEC1
    always_ff @(posedge clk) begin
        if (state == EXEC1)
            instrReg <= instructionT'(memReadData);
    end

    // live word in EXEC1, held copy afterwards
    assign instruction = (state == EXEC1) ? instructionT'(memReadData) : instrReg;

    // only reset leaves HALT
    haltSticky: assert property (
        @(posedge clk) disable iff (reset)
        state == HALT |=> state == HALT
    ) else $error("left HALT without reset");

endmodule

// ==== tb.f ====
hdl/mipsPkg.sv
hdl/mipsDecoder.sv
hdl/mipsSequencer.sv
hdl/mipsRegisterFile.sv
hdl/mipsAlu.sv
hdl/mipsProgramCounter.sv
hdl/mipsCore.sv
dv/mipsTbMemory.sv
dv/mipsCoreTb.sv
